// File: Bender.yml
package:
  name: fattree_noc

sources:
  - src/noc_params_pkg.sv
  - src/noc_flit_pkg.sv
  - src/router_input_fifo.sv
  - src/fattree_route.sv
  - src/router_top.sv
  - src/noc_cfg_regs.sv
  - src/fattree_noc_top.sv
  - target: test
    files:
      - tests/noc_checker.sv
      - tests/tb_fattree_noc.sv

// File: fattree_noc_top.f
src/noc_params_pkg.sv
src/noc_flit_pkg.sv
src/router_input_fifo.sv
src/fattree_route.sv
src/router_top.sv
src/noc_cfg_regs.sv
src/fattree_noc_top.sv
tests/noc_checker.sv
tests/tb_fattree_noc.sv

// File: src/fattree_noc_top.sv
`timescale 1ns/1ps
`default_nettype none

module fattree_noc_top #(
    parameter int K = noc_params_pkg::K_DEF
) (
    input  logic clk,
    input  logic arst_n,
    input  logic [noc_params_pkg::NE_OF(K)*noc_flit_pkg::FLIT_W-1:0] chan_in_flit,
    input  logic [noc_params_pkg::NE_OF(K)-1:0]                       chan_in_valid,
    output logic [noc_params_pkg::NE_OF(K)*noc_flit_pkg::FLIT_W-1:0] chan_out_flit,
    output logic [noc_params_pkg::NE_OF(K)-1:0]                       chan_out_valid,
    output logic [noc_params_pkg::NR_OF(K)*2*K*noc_flit_pkg::EV_W-1:0] router_event,
    input  logic                                         cfg_we,
    input  logic [$bits(noc_flit_pkg::cfg_addr_e)-1:0]   cfg_addr,
    input  logic [noc_flit_pkg::CFG_DATA_W-1:0]          cfg_wdata,
    output logic [noc_flit_pkg::CFG_DATA_W-1:0]          cfg_rdata
);
    import noc_params_pkg::*;
    import noc_flit_pkg::*;

    localparam int NE    = NE_OF(K);
    localparam int NR    = NR_OF(K);
    localparam int MAX_P = 2 * K;          // leaf port count
    localparam int FW    = FLIT_W;
    localparam int EVP   = MAX_P * EV_W;   // event bits per router slot

    // roots are ids 0..K-1, leaves are K..2K-1
    wire [K*FW-1:0]     root_in_flit   [K];
    wire [K-1:0]        root_in_valid  [K];
    wire [K*FW-1:0]     root_out_flit  [K];
    wire [K-1:0]        root_out_valid [K];
    wire [MAX_P*FW-1:0] leaf_in_flit   [K];
    wire [MAX_P-1:0]    leaf_in_valid  [K];
    wire [MAX_P*FW-1:0] leaf_out_flit  [K];
    wire [MAX_P-1:0]    leaf_out_valid [K];
    wire [NR-1:0]       drop_pulses;
    wire                net_enable;
    up_policy_e         up_policy;

    for (genvar r = 0; r < K; r++) begin : g_root
        router_top #(
            .K         (K),
            .P         (K),
            .IS_ROOT   (1'b1),
            .ROUTER_ID (r)
        ) u_router (
            .clk          (clk),
            .arst_n       (arst_n),
            .in_flit      (root_in_flit[r]),
            .in_valid     (root_in_valid[r]),
            .out_flit     (root_out_flit[r]),
            .out_valid    (root_out_valid[r]),
            .up_policy    (up_policy),
            .router_event (router_event[r*EVP +: K*EV_W]),
            .drop_pulse   (drop_pulses[r])
        );
        assign router_event[r*EVP + K*EV_W +: K*EV_W] = '0;   // roots have K ports only
    end

    for (genvar l = 0; l < K; l++) begin : g_leaf
        router_top #(
            .K         (K),
            .P         (MAX_P),
            .IS_ROOT   (1'b0),
            .ROUTER_ID (K + l)
        ) u_router (
            .clk          (clk),
            .arst_n       (arst_n),
            .in_flit      (leaf_in_flit[l]),
            .in_valid     (leaf_in_valid[l]),
            .out_flit     (leaf_out_flit[l]),
            .out_valid    (leaf_out_valid[l]),
            .up_policy    (up_policy),
            .router_event (router_event[(K+l)*EVP +: EVP]),
            .drop_pulse   (drop_pulses[K+l])
        );
    end

    // root r port j <-> leaf j port K+r
    for (genvar r = 0; r < K; r++) begin : g_link_r
        for (genvar j = 0; j < K; j++) begin : g_link_j
            assign root_in_flit[r][j*FW +: FW]       = leaf_out_flit[j][(K+r)*FW +: FW];
            assign root_in_valid[r][j]               = leaf_out_valid[j][K+r];
            assign leaf_in_flit[j][(K+r)*FW +: FW]   = root_out_flit[r][j*FW +: FW];
            assign leaf_in_valid[j][K+r]             = root_out_valid[r][j];
        end
    end

    // endpoint e on leaf e/K port e%K
    for (genvar e = 0; e < NE; e++) begin : g_ep
        assign leaf_in_flit[e/K][(e%K)*FW +: FW] = chan_in_flit[e*FW +: FW];
        assign leaf_in_valid[e/K][e%K]           = chan_in_valid[e] & net_enable;  // injection gate
        assign chan_out_flit[e*FW +: FW]         = leaf_out_flit[e/K][(e%K)*FW +: FW];
        assign chan_out_valid[e]                 = leaf_out_valid[e/K][e%K];
    end

    noc_cfg_regs #(
        .K (K)
    ) u_cfg (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .drop_pulses (drop_pulses),
        .cfg_rdata   (cfg_rdata),
        .net_enable  (net_enable),
        .up_policy   (up_policy)
    );

endmodule

`default_nettype wire

// File: src/fattree_route.sv
`timescale 1ns/1ps
`default_nettype none

module fattree_route #(
    parameter int K       = noc_params_pkg::K_DEF,
    parameter int P       = 2 * noc_params_pkg::K_DEF,
    parameter bit IS_ROOT = 1'b0,
    parameter int POS     = 0
) (
    input  logic [noc_flit_pkg::ADDR_W_MAX-1:0] dst,
    input  logic [noc_flit_pkg::ADDR_W_MAX-1:0] src,
    input  noc_flit_pkg::up_policy_e            up_policy,
    output logic [$clog2(P)-1:0]                out_port
);
    import noc_flit_pkg::*;

    localparam int PW = $clog2(P);

    // root ports 0..K-1 face leaves
    // leaf ports 0..K-1 face endpoints, K..2K-1 face roots
    always_comb begin
        int d;
        int s;
        d = int'(dst);
        s = int'(src);
        if (IS_ROOT) begin
            out_port = PW'(d / K);                 // down to the dst leaf
        end else if (d / K == POS) begin
            out_port = PW'(d % K);                 // local endpoint
        end else if (up_policy == UP_BY_SRC) begin
            out_port = PW'(K + s % K);             // root chosen by source
        end else begin
            out_port = PW'(K + d % K);             // root chosen by destination
        end
    end

endmodule

`default_nettype wire

// File: src/noc_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module noc_cfg_regs #(
    parameter int K = noc_params_pkg::K_DEF
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      cfg_we,
    input  logic [$bits(noc_flit_pkg::cfg_addr_e)-1:0] cfg_addr,
    input  logic [noc_flit_pkg::CFG_DATA_W-1:0]       cfg_wdata,
    input  logic [noc_params_pkg::NR_OF(K)-1:0]       drop_pulses,
    output logic [noc_flit_pkg::CFG_DATA_W-1:0]       cfg_rdata,
    output logic                                      net_enable,
    output noc_flit_pkg::up_policy_e                  up_policy
);
    import noc_flit_pkg::*;

    cfg_addr_e             addr;
    logic [CFG_DATA_W-1:0] drop_cnt;
    logic [CFG_DATA_W:0]   cnt_sum;    // extra bit flags overflow
    logic [CFG_DATA_W-1:0] cnt_next;

    assign addr = cfg_addr_e'(cfg_addr);

    // several routers may drop in the same cycle
    always_comb begin
        cnt_sum  = {1'b0, drop_cnt} + (CFG_DATA_W+1)'($countones(drop_pulses));
        cnt_next = cnt_sum[CFG_DATA_W] ? {CFG_DATA_W{1'b1}} : cnt_sum[CFG_DATA_W-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            net_enable <= 1'b0;
            up_policy  <= UP_BY_DST;
            drop_cnt   <= '0;
        end else begin
            drop_cnt <= cnt_next;
            if (cfg_we) begin
                case (addr)
                    CFG_ENABLE:     net_enable <= cfg_wdata[0];
                    CFG_UP_POLICY:  up_policy  <= up_policy_e'(cfg_wdata[0]);
                    CFG_DROP_COUNT: drop_cnt   <= '0;      // clear wins over new drops
                    default: ;
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        case (addr)
            CFG_ENABLE:     cfg_rdata = CFG_DATA_W'(net_enable);
            CFG_UP_POLICY:  cfg_rdata = CFG_DATA_W'(up_policy);
            CFG_DROP_COUNT: cfg_rdata = drop_cnt;
            default:        cfg_rdata = '0;
        endcase
    end

    a_cfg_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
        cfg_we |-> addr inside {CFG_ENABLE, CFG_UP_POLICY, CFG_DROP_COUNT})
        else $error("noc_cfg_regs: write to undefined address %0d", cfg_addr);

endmodule

`default_nettype wire

// File: src/noc_flit_pkg.sv
`default_nettype none

package noc_flit_pkg;

    localparam int PAYLOAD_W  = 16;
    localparam int ADDR_W_MAX = 4;     // dst and src fields, up to 16 endpoints

    // flit = {dst, src, payload}
    localparam int FLIT_W  = 2 * ADDR_W_MAX + PAYLOAD_W;
    localparam int SRC_LSB = PAYLOAD_W;
    localparam int DST_LSB = PAYLOAD_W + ADDR_W_MAX;

    localparam int CFG_DATA_W = 16;    // config data bus width

    // config register map
    typedef enum logic [1:0] {
        CFG_ENABLE     = 2'd0,         // bit 0 gates injection
        CFG_UP_POLICY  = 2'd1,         // bit 0 picks leaf up port rule
        CFG_DROP_COUNT = 2'd2          // read count, any write clears
    } cfg_addr_e;

    // which root a leaf sends non-local traffic to
    typedef enum logic {
        UP_BY_DST = 1'b0,
        UP_BY_SRC = 1'b1
    } up_policy_e;

    // per output arbiter state
    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_GRANT = 1'b1               // output register holds a flit
    } arb_state_e;

    // router event bits per port
    localparam int EV_W        = 3;
    localparam int EV_FLIT_IN  = 0;
    localparam int EV_FLIT_OUT = 1;
    localparam int EV_DROP     = 2;

endpackage

`default_nettype wire

// File: src/noc_params_pkg.sv
`default_nettype none

package noc_params_pkg;

    // two-level fat tree with K roots and K leaves
    localparam int K_DEF = 2;          // default radix

    localparam int FIFO_DEPTH = 4;     // entries per router input

    // endpoints hang off the leaves, K per leaf
    function automatic int NE_OF(input int k);
        return k * k;
    endfunction

    // K roots plus K leaves
    function automatic int NR_OF(input int k);
        return 2 * k;
    endfunction

    // endpoint index width
    function automatic int EW_OF(input int k);
        int ne;
        ne = k * k;
        if (ne <= 2) begin
            return 1;
        end
        return $clog2(ne);
    endfunction

endpackage

`default_nettype wire

// File: src/router_input_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module router_input_fifo #(
    parameter int DEPTH = 4,
    parameter int W     = 24
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic [W-1:0] in_flit,
    input  logic         in_valid,
    input  logic         pop,
    output logic [W-1:0] head_flit,
    output logic         head_valid,
    output logic         drop
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [W-1:0]  mem [DEPTH];    // circular storage
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;          // occupancy, 0..DEPTH
    logic          full;
    logic          push;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full       = (count == (PW+1)'(DEPTH));
    assign push       = in_valid && (!full || pop);   // pop frees the slot this cycle
    assign head_valid = (count != '0);
    assign head_flit  = mem[rd_ptr];                   // show-ahead head

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + (PW+1)'(push) - (PW+1)'(pop);
            drop  <= in_valid && full && !pop;          // one cycle pulse per lost flit
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // arbiter must only pop a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> head_valid)
        else $error("router_input_fifo: pop while empty");

endmodule

`default_nettype wire

// File: src/router_top.sv
`timescale 1ns/1ps
`default_nettype none

module router_top #(
    parameter int K         = noc_params_pkg::K_DEF,
    parameter int P         = 2 * noc_params_pkg::K_DEF,
    parameter bit IS_ROOT   = 1'b0,
    parameter int ROUTER_ID = 0
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [P*noc_flit_pkg::FLIT_W-1:0]   in_flit,
    input  logic [P-1:0]                        in_valid,
    output logic [P*noc_flit_pkg::FLIT_W-1:0]   out_flit,
    output logic [P-1:0]                        out_valid,
    input  noc_flit_pkg::up_policy_e            up_policy,
    output logic [P*noc_flit_pkg::EV_W-1:0]     router_event,
    output logic                                drop_pulse
);
    import noc_params_pkg::*;
    import noc_flit_pkg::*;

    localparam int PW  = $clog2(P);
    localparam int POS = IS_ROOT ? 0 : ROUTER_ID - K;   // leaves follow the roots in id order

    logic [FLIT_W-1:0] head_flit [P];
    logic [P-1:0]      head_valid;
    logic [P-1:0]      pop;
    logic [P-1:0]      drop;
    logic [PW-1:0]     route [P];      // requested output per input head
    logic [P-1:0]      req [P];        // req[o][i]
    logic [P-1:0]      gnt [P];        // gnt[o][i]
    logic [P-1:0]      gnt_col [P];    // gnt_col[i][o]
    logic [PW-1:0]     win [P];        // winning input per output
    logic [P-1:0]      gnt_any;
    logic [PW-1:0]     rr [P];         // round-robin start point
    arb_state_e        arb_q [P];
    logic [FLIT_W-1:0] out_q [P];
    logic [P-1:0]      flit_in_q;

    // does a flit with this dst belong on output o
    function automatic logic port_fits(input logic [FLIT_W-1:0] fl, input int o);
        int d;
        d = int'(fl[DST_LSB +: ADDR_W_MAX]);
        if (IS_ROOT) begin
            return d / K == o;
        end
        if (o < K) begin
            return (d / K == POS) && (d % K == o);
        end
        return d / K != POS;           // any up port, the root depends on policy
    endfunction

    for (genvar i = 0; i < P; i++) begin : g_in
        router_input_fifo #(
            .DEPTH (FIFO_DEPTH),
            .W     (FLIT_W)
        ) u_fifo (
            .clk        (clk),
            .arst_n     (arst_n),
            .in_flit    (in_flit[i*FLIT_W +: FLIT_W]),
            .in_valid   (in_valid[i]),
            .pop        (pop[i]),
            .head_flit  (head_flit[i]),
            .head_valid (head_valid[i]),
            .drop       (drop[i])
        );

        fattree_route #(
            .K       (K),
            .P       (P),
            .IS_ROOT (IS_ROOT),
            .POS     (POS)
        ) u_route (
            .dst       (head_flit[i][DST_LSB +: ADDR_W_MAX]),
            .src       (head_flit[i][SRC_LSB +: ADDR_W_MAX]),
            .up_policy (up_policy),
            .out_port  (route[i])
        );
    end

    // one grant per output, searching from rr
    always_comb begin
        int idx;
        for (int o = 0; o < P; o++) begin
            for (int i = 0; i < P; i++) begin
                req[o][i] = head_valid[i] && (route[i] == PW'(o));
            end
            gnt[o]     = '0;
            win[o]     = '0;
            gnt_any[o] = 1'b0;
            for (int n = 0; n < P; n++) begin
                idx = (int'(rr[o]) + n) % P;
                if (!gnt_any[o] && req[o][idx]) begin
                    gnt_any[o]  = 1'b1;
                    win[o]      = PW'(idx);
                    gnt[o][idx] = 1'b1;
                end
            end
        end
        for (int i = 0; i < P; i++) begin
            for (int o = 0; o < P; o++) begin
                gnt_col[i][o] = gnt[o][i];
            end
            pop[i] = |gnt_col[i];          // head leaves its FIFO when granted
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < P; o++) begin
                arb_q[o] <= ARB_IDLE;
                rr[o]    <= '0;
            end
            flit_in_q <= '0;
        end else begin
            flit_in_q <= in_valid;
            for (int o = 0; o < P; o++) begin
                arb_q[o] <= gnt_any[o] ? ARB_GRANT : ARB_IDLE;
                if (gnt_any[o]) begin
                    // winner goes to the back of the line
                    rr[o] <= (win[o] == PW'(P - 1)) ? '0 : win[o] + 1'b1;
                end
            end
        end
    end

    // output data regs
    always_ff @(posedge clk) begin
        for (int o = 0; o < P; o++) begin
            if (gnt_any[o]) begin
                out_q[o] <= head_flit[win[o]];
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out
        assign out_flit[o*FLIT_W +: FLIT_W] = out_q[o];
        assign out_valid[o]                 = (arb_q[o] == ARB_GRANT);

        assign router_event[o*EV_W + EV_FLIT_IN]  = flit_in_q[o];
        assign router_event[o*EV_W + EV_FLIT_OUT] = out_valid[o];   // same edge as the out reg
        assign router_event[o*EV_W + EV_DROP]     = drop[o];

        // registered flit on port o must be addressed through o
        a_out_route: assert property (@(posedge clk) disable iff (!arst_n)
            out_valid[o] |-> port_fits(out_q[o], o))
            else $error("router %0d: flit on port %0d misrouted", ROUTER_ID, o);

        // one input feeds one output at most
        a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(gnt_col[o]))
            else $error("router %0d: input %0d granted twice", ROUTER_ID, o);
    end

    assign drop_pulse = |drop;

endmodule

`default_nettype wire

// File: tests/noc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module noc_checker #(
    parameter int K = noc_params_pkg::K_DEF
) (
    input  logic clk,
    input  logic arst_n,
    input  logic [noc_params_pkg::NE_OF(K)*noc_flit_pkg::FLIT_W-1:0]   chan_in_flit,
    input  logic [noc_params_pkg::NE_OF(K)-1:0]                         chan_in_valid,
    input  logic [noc_params_pkg::NE_OF(K)*noc_flit_pkg::FLIT_W-1:0]   chan_out_flit,
    input  logic [noc_params_pkg::NE_OF(K)-1:0]                         chan_out_valid,
    input  logic [noc_params_pkg::NR_OF(K)*2*K*noc_flit_pkg::EV_W-1:0] router_event,
    input  logic                                       cfg_we,
    input  logic [$bits(noc_flit_pkg::cfg_addr_e)-1:0] cfg_addr,
    input  logic [noc_flit_pkg::CFG_DATA_W-1:0]        cfg_wdata,
    input  logic [noc_flit_pkg::CFG_DATA_W-1:0]        cfg_rdata,
    input  logic                                       sync,       // drained, check totals
    output int                                         errors,
    output int                                         injected,
    output int                                         delivered,
    output int                                         dropped
);
    import noc_params_pkg::*;
    import noc_flit_pkg::*;

    localparam int NE  = NE_OF(K);
    localparam int NR  = NR_OF(K);
    localparam int EVP = 2 * K * EV_W;     // event bits per router slot

    logic [FLIT_W-1:0] exp_q [$];          // outstanding flits, any order
    int                lost;               // drops since last sync
    int                drop_total;         // mirrors the hw drop counter
    int                pend [K];           // flits still due at each root
    logic              en_m;               // register model from the cfg bus
    logic              pol_m;
    logic [FLIT_W-1:0] f;
    int                exp_rd;
    int                root;
    logic              found;
    logic              rdrop;              // any port of one router dropped

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            lost       = 0;
            drop_total = 0;
            en_m       = 1'b0;
            pol_m      = 1'b0;
            errors     = 0;
            injected   = 0;
            delivered  = 0;
            dropped    = 0;
            for (int r = 0; r < K; r++) begin
                pend[r] = 0;
            end
        end else begin
            // end of a test, rdata reflects state before this edge
            if (sync) begin
                case (cfg_addr)
                    CFG_ENABLE:    exp_rd = int'(en_m);
                    CFG_UP_POLICY: exp_rd = int'(pol_m);
                    default:       exp_rd = drop_total;
                endcase
                if (int'(cfg_rdata) != exp_rd) begin
                    $display("MISMATCH t=%0t cfg_rdata (addr %0d) expected %0d got %0d",
                             $time, cfg_addr, exp_rd, cfg_rdata);
                    errors++;
                end
                if (exp_q.size() != lost) begin
                    $display("%0d flits never arrived but %0d were dropped", exp_q.size(), lost);
                    errors++;
                end
                exp_q.delete();
                lost = 0;
                for (int r = 0; r < K; r++) begin
                    pend[r] = 0;
                end
            end
            // nothing may move while injection is gated
            if (!en_m && (|router_event || |chan_out_valid)) begin
                $display("network activity at t=%0t while disabled", $time);
                errors++;
            end
            for (int e = 0; e < NE; e++) begin
                f = chan_in_flit[e*FLIT_W +: FLIT_W];
                if (chan_in_valid[e] && en_m) begin
                    exp_q.push_back(f);
                    injected++;
                    // cross-leaf flits must pass the root named by the policy
                    if (int'(f[DST_LSB +: ADDR_W_MAX]) / K != e / K) begin
                        root = pol_m ? int'(f[SRC_LSB +: ADDR_W_MAX]) % K
                                     : int'(f[DST_LSB +: ADDR_W_MAX]) % K;
                        pend[root]++;
                    end
                end
            end
            for (int e = 0; e < NE; e++) begin
                f = chan_out_flit[e*FLIT_W +: FLIT_W];
                if (chan_out_valid[e]) begin
                    found = 1'b0;
                    for (int i = 0; i < exp_q.size(); i++) begin
                        if (!found && exp_q[i] == f) begin
                            exp_q.delete(i);
                            found = 1'b1;
                        end
                    end
                    if (int'(f[DST_LSB +: ADDR_W_MAX]) != e) begin
                        $display("MISMATCH t=%0t chan_out_flit[%0d] expected dst %0d got %h",
                                 $time, e, e, f);
                        errors++;
                    end else if (!found) begin
                        $display("MISMATCH t=%0t chan_out_flit[%0d] expected an injected flit got %h",
                                 $time, e, f);
                        errors++;
                    end else begin
                        delivered++;
                    end
                end
            end
            for (int r = 0; r < K; r++) begin
                for (int j = 0; j < K; j++) begin
                    if (router_event[r*EVP + j*EV_W + EV_FLIT_IN]) begin
                        if (pend[r] == 0) begin
                            $display("flit entered root %0d at t=%0t against the up policy",
                                     r, $time);
                            errors++;
                        end else begin
                            pend[r]--;
                        end
                    end
                end
            end
            for (int r = 0; r < NR; r++) begin
                rdrop = 1'b0;
                for (int p = 0; p < 2 * K; p++) begin
                    if (router_event[r*EVP + p*EV_W + EV_DROP]) begin
                        dropped++;
                        lost++;
                        rdrop = 1'b1;
                    end
                end
                // hw counter adds one per router pulse and saturates
                if (rdrop && drop_total < 65535) begin
                    drop_total++;
                end
            end
            // writes land after this edge's traffic, like the DUT
            if (cfg_we) begin
                case (cfg_addr)
                    CFG_ENABLE:     en_m = cfg_wdata[0];
                    CFG_UP_POLICY:  pol_m = cfg_wdata[0];
                    CFG_DROP_COUNT: drop_total = 0;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_fattree_noc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fattree_noc;
    import noc_params_pkg::*;
    import noc_flit_pkg::*;

    localparam int K  = 2;
    localparam int NE = NE_OF(K);
    localparam int NR = NR_OF(K);
    localparam int FW = FLIT_W;

    logic                       clk;
    logic                       arst_n;
    logic [NE*FW-1:0]           chan_in_flit;
    logic [NE-1:0]              chan_in_valid;
    wire  [NE*FW-1:0]           chan_out_flit;
    wire  [NE-1:0]              chan_out_valid;
    wire  [NR*2*K*EV_W-1:0]     router_event;
    logic                       cfg_we;
    logic [1:0]                 cfg_addr;
    logic [CFG_DATA_W-1:0]      cfg_wdata;
    wire  [CFG_DATA_W-1:0]      cfg_rdata;
    logic                       sync;
    int                         errors;
    int                         injected;
    int                         delivered;
    int                         dropped;
    int                         tb_errs;          // timeouts and tb-side failures
    int                         n_pass;
    int                         n_fail;
    int                         err_mark;
    int                         drop_mark;

    fattree_noc_top #(.K(K)) dut (
        .clk(clk), .arst_n(arst_n),
        .chan_in_flit(chan_in_flit), .chan_in_valid(chan_in_valid),
        .chan_out_flit(chan_out_flit), .chan_out_valid(chan_out_valid),
        .router_event(router_event),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    noc_checker #(.K(K)) chk (
        .clk(clk), .arst_n(arst_n),
        .chan_in_flit(chan_in_flit), .chan_in_valid(chan_in_valid),
        .chan_out_flit(chan_out_flit), .chan_out_valid(chan_out_valid),
        .router_event(router_event),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .sync(sync), .errors(errors), .injected(injected),
        .delivered(delivered), .dropped(dropped)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    // inputs change 5 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    function automatic logic [FW-1:0] make_flit(input int dst, input int src, input int pl);
        logic [FW-1:0] fl;
        fl = '0;
        fl[DST_LSB +: ADDR_W_MAX] = ADDR_W_MAX'(dst);
        fl[SRC_LSB +: ADDR_W_MAX] = ADDR_W_MAX'(src);
        fl[PAYLOAD_W-1:0]         = PAYLOAD_W'(pl);
        return fl;
    endfunction

    task automatic cfg_write(input cfg_addr_e a, input int data);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = CFG_DATA_W'(data);
        next_cycle();
        cfg_we    = 1'b0;
    endtask

    task automatic send_flit(input int src, input int dst);
        chan_in_flit[src*FW +: FW] = make_flit(dst, src, $urandom);
        chan_in_valid[src]         = 1'b1;
        next_cycle();
        chan_in_valid              = '0;
    endtask

    task automatic wait_delivery(input int dst);
        int n;
        n = 0;
        while (!chan_out_valid[dst] && n < 100) begin
            next_cycle();
            n++;
        end
        if (!chan_out_valid[dst]) begin
            $display("timeout: no flit reached endpoint %0d", dst);
            tb_errs++;
        end
    endtask

    // idle once nothing has moved for a few cycles
    task automatic wait_drain();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 8 && n < 3000) begin
            next_cycle();
            n++;
            quiet = (|chan_out_valid || |router_event) ? 0 : quiet + 1;
        end
        if (quiet < 8) begin
            $display("timeout: network did not go idle");
            tb_errs++;
        end
    endtask

    task automatic end_check(input cfg_addr_e a);
        cfg_addr = a;
        sync     = 1'b1;
        next_cycle();
        sync     = 1'b0;
    endtask

    task automatic test_done(input int num, input string name);
        if (errors + tb_errs == err_mark) begin
            n_pass++;
            $display("test %0d %s: pass", num, name);
        end else begin
            n_fail++;
            $display("test %0d %s: FAIL", num, name);
        end
        err_mark  = errors + tb_errs;
        drop_mark = dropped;
    endtask

    initial begin
        int inj;
        arst_n        = 1'b0;
        chan_in_flit  = '0;
        chan_in_valid = '0;
        cfg_we        = 1'b0;
        cfg_addr      = CFG_DROP_COUNT;
        cfg_wdata     = '0;
        sync          = 1'b0;
        tb_errs       = 0;
        n_pass        = 0;
        n_fail        = 0;
        err_mark      = 0;
        drop_mark     = 0;
        void'($urandom(32'hece8));
        repeat (3) @(posedge clk);
        #5;
        arst_n = 1'b1;
        next_cycle();
        cfg_write(CFG_ENABLE, 1);

        // every source to every destination, one flit at a time
        for (int s = 0; s < NE; s++) begin
            for (int d = 0; d < NE; d++) begin
                send_flit(s, d);
                wait_delivery(d);
                wait_drain();
            end
        end
        end_check(CFG_DROP_COUNT);
        if (dropped != drop_mark) begin
            $display("flits were dropped on an idle network");
            tb_errs++;
        end
        test_done(1, "idle routing");

        // cross-leaf traffic under both root choices
        for (int p = 0; p < 2; p++) begin
            cfg_write(CFG_UP_POLICY, p);
            for (int s = 0; s < NE; s++) begin
                for (int d = 0; d < NE; d++) begin
                    if (s / K != d / K) begin
                        send_flit(s, d);
                        wait_delivery(d);
                        wait_drain();
                    end
                end
            end
        end
        end_check(CFG_UP_POLICY);
        test_done(2, "up policy");

        cfg_write(CFG_ENABLE, 0);
        repeat (20) begin
            for (int e = 0; e < NE; e++) begin
                chan_in_flit[e*FW +: FW] = make_flit($urandom_range(NE - 1, 0), e, $urandom);
                chan_in_valid[e]         = 1'($urandom_range(1, 0));
            end
            next_cycle();
        end
        chan_in_valid = '0;
        wait_drain();
        cfg_write(CFG_ENABLE, 1);
        for (int n = 0; n < 4; n++) begin
            inj = $urandom_range(NE - 1, 0);    // destination
            send_flit($urandom_range(NE - 1, 0), inj);
            wait_delivery(inj);
            wait_drain();
        end
        end_check(CFG_ENABLE);
        test_done(3, "enable gate");

        // half-rate random load on every endpoint
        inj = 0;
        for (int c = 0; c < 4000 && inj < 500; c++) begin
            for (int e = 0; e < NE; e++) begin
                chan_in_valid[e] = 1'b0;
                if (inj < 500 && $urandom_range(1, 0) == 1) begin
                    chan_in_flit[e*FW +: FW] = make_flit($urandom_range(NE - 1, 0), e, $urandom);
                    chan_in_valid[e]         = 1'b1;
                    inj++;
                end
            end
            next_cycle();
        end
        chan_in_valid = '0;
        wait_drain();
        end_check(CFG_DROP_COUNT);
        // every flit since reset is either delivered or dropped
        if (delivered + dropped != injected) begin
            $display("%0d flits injected but %0d delivered and %0d dropped",
                     injected, delivered, dropped);
            tb_errs++;
        end
        test_done(4, $sformatf("random load (%0d sent, %0d dropped)", inj, dropped - drop_mark));

        cfg_write(CFG_DROP_COUNT, 16'h1234);
        end_check(CFG_DROP_COUNT);
        end_check(CFG_ENABLE);
        end_check(CFG_UP_POLICY);
        test_done(5, "drop counter clear");

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
